//--- list.f
corr_pkg.sv
axil_pkg.sv
corr_cfg_if.sv
corr_regs.sv
sliding_dft.sv
correlation_mults.sv
corr_accumulate.sv
msdft_correlator.sv
msdft_correlator_assertions.sv
tb_msdft_correlator.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_msdft_correlator -f list.f \
    && ./obj_dir/Vtb_msdft_correlator | tee /dev/stderr | grep "All checks passed" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb_msdft_correlator.sv
`timescale 1ns/10ps
`default_nettype none

module tb_msdft_correlator;

    localparam int DFT_LEN = 16;
    localparam int total_samples = 124;
    localparam int total_trans = 30;
    // a sample can cost two cycles, an AXI access about eight, plus drain and reset
    localparam int timeout_cycles = 2 * (2 * total_samples + 8 * total_trans + 100);

    logic clk;
    logic rst;
    logic signed [corr_pkg::din_width-1:0] din1_re, din1_im, din2_re, din2_im;
    logic din_valid;
    logic signed [corr_pkg::acc_width-1:0] r12_re, r12_im;
    logic [corr_pkg::acc_width-1:0] r11, r22;
    logic dout_valid;
    logic [axil_pkg::addr_width-1:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;

    // reference model state
    int m_dly_re [2][DFT_LEN];
    int m_dly_im [2][DFT_LEN];
    int m_st_re [2];
    int m_st_im [2];
    logic [31:0] m_acc [4];
    int m_count;
    int m_tw_re;
    int m_tw_im;
    int m_acc_len;
    bit m_enable;
    logic [127:0] exp_q [$];
    logic [127:0] want;

    integer seed;
    int errors;
    int checks;
    int pulses;
    int cycles;

    msdft_correlator #(.DFT_LEN(DFT_LEN)) dut0 (.*);

    bind corr_regs msdft_correlator_assertions regs_chk (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awready(awready), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rready(rready),
        .dout_valid(1'b0), .acc_len(32'd1)
    );

    bind corr_accumulate msdft_correlator_assertions acc_chk (
        .clk(clk), .rst(rst),
        .awvalid(1'b0), .awready(1'b0), .wvalid(1'b0), .wready(1'b0),
        .bvalid(1'b0), .bready(1'b0), .arvalid(1'b0), .arready(1'b0),
        .rvalid(1'b0), .rready(1'b0),
        .dout_valid(dout_valid), .acc_len(cfg.acc_len)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout, run did not finish within %0d cycles", timeout_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic int wrap_bin(input longint v);
        logic signed [corr_pkg::sdft_width-1:0] t;
        t = v[corr_pkg::sdft_width-1:0];
        return int'(t);
    endfunction

    task automatic expect_equal(input logic [127:0] got, input logic [127:0] exp_val,
                                input string what);
        checks++;
        assert (got === exp_val) else begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp_val);
            errors++;
        end
    endtask

    task automatic model_reset();
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < DFT_LEN; i++) begin
                m_dly_re[c][i] = 0;
                m_dly_im[c][i] = 0;
            end
            m_st_re[c] = 0;
            m_st_im[c] = 0;
        end
        for (int k = 0; k < 4; k++) begin
            m_acc[k] = '0;
        end
        m_count = 0;
        m_tw_re = 16384;
        m_tw_im = 0;
        m_acc_len = 1;
        exp_q.delete();
    endtask

    task automatic model_step(input int x1_re, input int x1_im,
                              input int x2_re, input int x2_im);
        int x_re [2];
        int x_im [2];
        longint s_re;
        longint s_im;
        longint b [4];
        logic [31:0] prod [4];
        x_re[0] = x1_re;
        x_im[0] = x1_im;
        x_re[1] = x2_re;
        x_im[1] = x2_im;
        for (int c = 0; c < 2; c++) begin
            // new sample in, oldest sample out
            s_re = longint'(m_st_re[c]) + x_re[c] - m_dly_re[c][DFT_LEN-1];
            s_im = longint'(m_st_im[c]) + x_im[c] - m_dly_im[c][DFT_LEN-1];
            for (int i = DFT_LEN - 1; i > 0; i--) begin
                m_dly_re[c][i] = m_dly_re[c][i-1];
                m_dly_im[c][i] = m_dly_im[c][i-1];
            end
            m_dly_re[c][0] = x_re[c];
            m_dly_im[c][0] = x_im[c];
            m_st_re[c] = wrap_bin((s_re * m_tw_re - s_im * m_tw_im) >>> corr_pkg::twidd_point);
            m_st_im[c] = wrap_bin((s_re * m_tw_im + s_im * m_tw_re) >>> corr_pkg::twidd_point);
        end
        b[0] = m_st_re[0];
        b[1] = m_st_im[0];
        b[2] = m_st_re[1];
        b[3] = m_st_im[1];
        // bin 1 times conj of bin 2, then both powers
        prod[0] = 32'((b[0] * b[2] + b[1] * b[3]) >>> corr_pkg::prod_shift);
        prod[1] = 32'((b[1] * b[2] - b[0] * b[3]) >>> corr_pkg::prod_shift);
        prod[2] = 32'((b[0] * b[0] + b[1] * b[1]) >>> corr_pkg::prod_shift);
        prod[3] = 32'((b[2] * b[2] + b[3] * b[3]) >>> corr_pkg::prod_shift);
        for (int k = 0; k < 4; k++) begin
            m_acc[k] = m_acc[k] + prod[k];
        end
        m_count++;
        if (m_count >= m_acc_len) begin
            exp_q.push_back({m_acc[0], m_acc[1], m_acc[2], m_acc[3]});
            m_count = 0;
            for (int k = 0; k < 4; k++) begin
                m_acc[k] = '0;
            end
        end
    endtask

    // frame results, sampled away from the driving edge
    always @(negedge clk) begin
        if (!rst && dout_valid) begin
            pulses++;
            checks++;
            assert (exp_q.size() != 0) else begin
                $display("dout_valid arrived at %0t with no frame expected", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                expect_equal({r12_re, r12_im, r11, r22}, want, "frame result");
            end
        end
    end

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        bit aw_done;
        bit w_done;
        aw_done = 1'b0;
        w_done = 1'b0;
        @(posedge clk);
        awaddr <= addr;
        awvalid <= 1'b1;
        wdata <= data;
        wstrb <= strb;
        wvalid <= 1'b1;
        while (!(aw_done && w_done)) begin
            @(posedge clk);
            if (awvalid && awready) begin
                awvalid <= 1'b0;
                aw_done = 1'b1;
            end
            if (wvalid && wready) begin
                wvalid <= 1'b0;
                w_done = 1'b1;
            end
        end
        do @(posedge clk); while (!bvalid);
        // let the response wait a few cycles
        repeat ($random(seed) & 3) @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        araddr <= addr;
        arvalid <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        do @(posedge clk); while (!rvalid);
        // let the response wait a few cycles
        repeat ($random(seed) & 3) @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                                input logic [3:0] strb, input logic [1:0] want_resp);
        logic [1:0] resp;
        axil_write(addr, data, strb, resp);
        expect_equal(128'(resp), 128'(want_resp), "write response");
    endtask

    task automatic read_expect(input logic [7:0] addr, input logic [31:0] want_data,
                               input logic [1:0] want_resp);
        logic [31:0] data;
        logic [1:0] resp;
        axil_read(addr, data, resp);
        expect_equal(128'(resp), 128'(want_resp), "read response");
        expect_equal(128'(data), 128'(want_data), "read data");
    endtask

    task automatic set_enable(input bit en);
        write_expect(axil_pkg::addr_ctrl, {31'd0, en}, 4'hf, axil_pkg::okay);
        m_enable = en;
    endtask

    task automatic send_samples(input int n);
        logic signed [7:0] s [4];
        for (int k = 0; k < n; k++) begin
            for (int j = 0; j < 4; j++) begin
                s[j] = 8'($random(seed));
            end
            @(posedge clk);
            din1_re <= s[0];
            din1_im <= s[1];
            din2_re <= s[2];
            din2_im <= s[3];
            din_valid <= 1'b1;
            if (m_enable) begin
                model_step(s[0], s[1], s[2], s[3]);
            end
            // occasional gap in the stream
            if (($random(seed) & 3) == 0) begin
                @(posedge clk);
                din_valid <= 1'b0;
            end
        end
        @(posedge clk);
        din_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // room for a stray pulse to show up
        repeat (8) @(posedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        // handshake and valid outputs all low in reset
        expect_equal(128'({awready, wready, arready, bvalid, rvalid, dout_valid}), 128'(0),
                     "outputs in reset");
        rst <= 1'b0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_registers();
        int e0;
        e0 = errors;
        read_expect(axil_pkg::addr_frames, 32'd0, axil_pkg::okay);
        read_expect(axil_pkg::addr_ctrl, 32'd0, axil_pkg::okay);
        read_expect(axil_pkg::addr_twiddle, 32'h0000_4000, axil_pkg::okay);
        read_expect(axil_pkg::addr_acc_len, 32'd1, axil_pkg::okay);
        write_expect(axil_pkg::addr_twiddle, 32'h1234_5678, 4'hf, axil_pkg::okay);
        write_expect(axil_pkg::addr_twiddle, 32'haabb_ccdd, 4'b0110, axil_pkg::okay);
        read_expect(axil_pkg::addr_twiddle, 32'h12bb_cc78, axil_pkg::okay);
        write_expect(axil_pkg::addr_acc_len, 32'h0000_0100, 4'hf, axil_pkg::okay);
        write_expect(axil_pkg::addr_acc_len, 32'hffff_ff07, 4'b0001, axil_pkg::okay);
        read_expect(axil_pkg::addr_acc_len, 32'h0000_0107, axil_pkg::okay);
        write_expect(axil_pkg::addr_frames, 32'h5a5a_5a5a, 4'hf, axil_pkg::okay);
        read_expect(axil_pkg::addr_frames, 32'd0, axil_pkg::okay);
        write_expect(8'h10, 32'd1, 4'hf, axil_pkg::slverr);
        read_expect(8'h10, 32'd0, axil_pkg::slverr);
        // back to unity twiddle and one-sample frames
        write_expect(axil_pkg::addr_twiddle, 32'h0000_4000, 4'hf, axil_pkg::okay);
        write_expect(axil_pkg::addr_acc_len, 32'd1, 4'hf, axil_pkg::okay);
        report_test("register access", e0);
    endtask

    task automatic test_unity();
        int e0;
        int p0;
        e0 = errors;
        p0 = pulses;
        set_enable(1'b1);
        send_samples(40);
        wait_drain();
        expect_equal(128'(pulses - p0), 128'(40), "frames with acc_len 1");
        report_test("unity twiddle", e0);
    endtask

    task automatic test_twiddle_j();
        int e0;
        int p0;
        e0 = errors;
        p0 = pulses;
        write_expect(axil_pkg::addr_twiddle, 32'h4000_0000, 4'hf, axil_pkg::okay);
        m_tw_re = 0;
        m_tw_im = 16384;
        write_expect(axil_pkg::addr_acc_len, 32'd4, 4'hf, axil_pkg::okay);
        m_acc_len = 4;
        send_samples(32);
        wait_drain();
        expect_equal(128'(pulses - p0), 128'(8), "frames with acc_len 4");
        report_test("twiddle j", e0);
    endtask

    task automatic test_disabled();
        int e0;
        int p0;
        e0 = errors;
        p0 = pulses;
        set_enable(1'b0);
        send_samples(20);
        repeat (10) @(posedge clk);
        expect_equal(128'(pulses - p0), 128'(0), "frames while disabled");
        // model was not advanced, so these frames show the DUT state held too
        set_enable(1'b1);
        send_samples(8);
        wait_drain();
        expect_equal(128'(pulses - p0), 128'(2), "frames after enable");
        report_test("enable cleared", e0);
    endtask

    task automatic test_frames_reset();
        int e0;
        e0 = errors;
        read_expect(axil_pkg::addr_frames, 32'(pulses), axil_pkg::okay);
        apply_reset();
        model_reset();
        m_enable = 1'b0;
        pulses = 0;
        read_expect(axil_pkg::addr_frames, 32'd0, axil_pkg::okay);
        set_enable(1'b1);
        send_samples(24);
        wait_drain();
        expect_equal(128'(pulses), 128'(24), "frames after reset");
        report_test("frame count and reset", e0);
    endtask

    initial begin
        seed = 32'hc9ad7d42;
        clk = 1'b0;
        rst = 1'b1;
        din1_re = '0;
        din1_im = '0;
        din2_re = '0;
        din2_im = '0;
        din_valid = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        errors = 0;
        checks = 0;
        pulses = 0;
        cycles = 0;
        m_enable = 1'b0;
        model_reset();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_registers();
        test_unity();
        test_twiddle_j();
        test_disabled();
        test_frames_reset();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- msdft_correlator_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module msdft_correlator_assertions (
    input wire logic clk,
    input wire logic rst,
    input wire logic awvalid,
    input wire logic awready,
    input wire logic wvalid,
    input wire logic wready,
    input wire logic bvalid,
    input wire logic bready,
    input wire logic arvalid,
    input wire logic arready,
    input wire logic rvalid,
    input wire logic rready,
    input wire logic dout_valid,
    input wire logic [31:0] acc_len
);

    // request channels, valid stays up until accepted
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    // response channels under back-pressure
    b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // no new address taken while a response waits
    b_block: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> !awready && !wready)
        else $error("write channel ready while bvalid waits");

    r_block: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> !arready)
        else $error("arready high while rvalid waits");

    // frames longer than one product give isolated pulses
    single_pulse: assert property (@(posedge clk) disable iff (rst)
        dout_valid && (acc_len > 32'd1) |=> !dout_valid)
        else $error("dout_valid high on two cycles in a row");

endmodule

`default_nettype wire

//--- msdft_correlator.sv
`timescale 1ns/10ps
`default_nettype none

module msdft_correlator #(
    parameter int DFT_LEN = 16
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic signed [corr_pkg::din_width-1:0] din1_re,
    input  wire logic signed [corr_pkg::din_width-1:0] din1_im,
    input  wire logic signed [corr_pkg::din_width-1:0] din2_re,
    input  wire logic signed [corr_pkg::din_width-1:0] din2_im,
    input  wire logic din_valid,
    output logic signed [corr_pkg::acc_width-1:0] r12_re,
    output logic signed [corr_pkg::acc_width-1:0] r12_im,
    output logic [corr_pkg::acc_width-1:0] r11,
    output logic [corr_pkg::acc_width-1:0] r22,
    output logic dout_valid,
    input  wire logic [axil_pkg::addr_width-1:0] awaddr,
    input  wire logic awvalid,
    output logic awready,
    input  wire logic [31:0] wdata,
    input  wire logic [3:0] wstrb,
    input  wire logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  wire logic bready,
    input  wire logic [axil_pkg::addr_width-1:0] araddr,
    input  wire logic arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  wire logic rready
);

    corr_cfg_if cfg ();

    logic sample_valid;
    logic signed [corr_pkg::sdft_width-1:0] bin1_re, bin1_im, bin2_re, bin2_im;
    logic bin_valid;
    logic signed [corr_pkg::acc_width-1:0] corr_re, corr_im;
    logic [corr_pkg::acc_width-1:0] pow1, pow2;
    logic prod_valid;

    // samples only count while enabled
    assign sample_valid = din_valid && cfg.enable;

    corr_regs regs0 (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .cfg(cfg.regs)
    );

    sliding_dft #(.DFT_LEN(DFT_LEN)) sdft1 (
        .clk(clk), .rst(rst),
        .din_re(din1_re), .din_im(din1_im), .din_valid(sample_valid),
        .cfg(cfg.dp),
        .dout_re(bin1_re), .dout_im(bin1_im), .dout_valid(bin_valid)
    );

    // same timing as sdft1, its valid is not needed
    sliding_dft #(.DFT_LEN(DFT_LEN)) sdft2 (
        .clk(clk), .rst(rst),
        .din_re(din2_re), .din_im(din2_im), .din_valid(sample_valid),
        .cfg(cfg.dp),
        .dout_re(bin2_re), .dout_im(bin2_im), .dout_valid()
    );

    correlation_mults mults0 (
        .clk(clk), .rst(rst),
        .din1_re(bin1_re), .din1_im(bin1_im),
        .din2_re(bin2_re), .din2_im(bin2_im),
        .din_valid(bin_valid),
        .corr_re(corr_re), .corr_im(corr_im),
        .pow1(pow1), .pow2(pow2),
        .dout_valid(prod_valid)
    );

    corr_accumulate acc0 (
        .clk(clk), .rst(rst),
        .corr_re(corr_re), .corr_im(corr_im),
        .pow1(pow1), .pow2(pow2),
        .din_valid(prod_valid),
        .cfg(cfg.dp),
        .r12_re(r12_re), .r12_im(r12_im),
        .r11(r11), .r22(r22),
        .dout_valid(dout_valid)
    );

endmodule

`default_nettype wire

//--- corr_accumulate.sv
`timescale 1ns/10ps
`default_nettype none

module corr_accumulate (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic signed [corr_pkg::acc_width-1:0] corr_re,
    input  wire logic signed [corr_pkg::acc_width-1:0] corr_im,
    input  wire logic [corr_pkg::acc_width-1:0] pow1,
    input  wire logic [corr_pkg::acc_width-1:0] pow2,
    input  wire logic din_valid,
    corr_cfg_if.dp cfg,
    output logic signed [corr_pkg::acc_width-1:0] r12_re,
    output logic signed [corr_pkg::acc_width-1:0] r12_im,
    output logic [corr_pkg::acc_width-1:0] r11,
    output logic [corr_pkg::acc_width-1:0] r22,
    output logic dout_valid
);

    logic [31:0] count;
    logic last;
    logic signed [corr_pkg::acc_width-1:0] acc_re;
    logic signed [corr_pkg::acc_width-1:0] acc_im;
    logic [corr_pkg::acc_width-1:0] acc_p1;
    logic [corr_pkg::acc_width-1:0] acc_p2;

    // >= so a shortened length mid frame still closes it
    assign last = (count + 32'd1) >= cfg.acc_len;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= 32'd0;
            acc_re <= '0;
            acc_im <= '0;
            acc_p1 <= '0;
            acc_p2 <= '0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid && last;
            if (din_valid && last) begin
                r12_re <= acc_re + corr_re;
                r12_im <= acc_im + corr_im;
                r11 <= acc_p1 + pow1;
                r22 <= acc_p2 + pow2;
                count <= 32'd0;
                acc_re <= '0;
                acc_im <= '0;
                acc_p1 <= '0;
                acc_p2 <= '0;
            end else if (din_valid) begin
                count <= count + 32'd1;
                acc_re <= acc_re + corr_re;
                acc_im <= acc_im + corr_im;
                acc_p1 <= acc_p1 + pow1;
                acc_p2 <= acc_p2 + pow2;
            end
        end
    end

    assign cfg.frame_done = dout_valid;

endmodule

`default_nettype wire

//--- correlation_mults.sv
`timescale 1ns/10ps
`default_nettype none

module correlation_mults (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic signed [corr_pkg::sdft_width-1:0] din1_re,
    input  wire logic signed [corr_pkg::sdft_width-1:0] din1_im,
    input  wire logic signed [corr_pkg::sdft_width-1:0] din2_re,
    input  wire logic signed [corr_pkg::sdft_width-1:0] din2_im,
    input  wire logic din_valid,
    output logic signed [corr_pkg::acc_width-1:0] corr_re,
    output logic signed [corr_pkg::acc_width-1:0] corr_im,
    output logic [corr_pkg::acc_width-1:0] pow1,
    output logic [corr_pkg::acc_width-1:0] pow2,
    output logic dout_valid
);

    logic signed [corr_pkg::prod_width-1:0] cross_re;
    logic signed [corr_pkg::prod_width-1:0] cross_im;
    logic signed [corr_pkg::prod_width-1:0] mag1;
    logic signed [corr_pkg::prod_width-1:0] mag2;

    // x1 * conj(x2)
    always_comb begin
        cross_re = din1_re * din2_re + din1_im * din2_im;
        cross_im = din1_im * din2_re - din1_re * din2_im;
        mag1 = din1_re * din1_re + din1_im * din1_im;
        mag2 = din2_re * din2_re + din2_im * din2_im;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
        end
        corr_re <= corr_pkg::acc_width'(cross_re >>> corr_pkg::prod_shift);
        corr_im <= corr_pkg::acc_width'(cross_im >>> corr_pkg::prod_shift);
        // powers are never negative
        pow1 <= corr_pkg::acc_width'(mag1 >>> corr_pkg::prod_shift);
        pow2 <= corr_pkg::acc_width'(mag2 >>> corr_pkg::prod_shift);
    end

endmodule

`default_nettype wire

//--- sliding_dft.sv
`timescale 1ns/10ps
`default_nettype none

module sliding_dft #(
    parameter int DFT_LEN = 16
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic signed [corr_pkg::din_width-1:0] din_re,
    input  wire logic signed [corr_pkg::din_width-1:0] din_im,
    input  wire logic din_valid,
    corr_cfg_if.dp cfg,
    output logic signed [corr_pkg::sdft_width-1:0] dout_re,
    output logic signed [corr_pkg::sdft_width-1:0] dout_im,
    output logic dout_valid
);

    localparam int sum_width = corr_pkg::sdft_width + 1;
    localparam int mul_width = sum_width + corr_pkg::twidd_width + 1;

    logic signed [corr_pkg::din_width-1:0] dly_re [DFT_LEN];
    logic signed [corr_pkg::din_width-1:0] dly_im [DFT_LEN];
    logic signed [corr_pkg::din_width:0] delta_re;
    logic signed [corr_pkg::din_width:0] delta_im;
    logic delta_valid;
    logic signed [sum_width-1:0] sum_re;
    logic signed [sum_width-1:0] sum_im;
    logic signed [mul_width-1:0] mul_re;
    logic signed [mul_width-1:0] mul_im;

    // window delay line, oldest sample at the far end
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DFT_LEN; i++) begin
                dly_re[i] <= '0;
                dly_im[i] <= '0;
            end
        end else if (din_valid) begin
            dly_re[0] <= din_re;
            dly_im[0] <= din_im;
            for (int i = 1; i < DFT_LEN; i++) begin
                dly_re[i] <= dly_re[i-1];
                dly_im[i] <= dly_im[i-1];
            end
        end
    end

    // stage 1: entering sample minus leaving sample
    always_ff @(posedge clk) begin
        if (rst) begin
            delta_valid <= 1'b0;
        end else begin
            delta_valid <= din_valid;
        end
        if (din_valid) begin
            delta_re <= din_re - dly_re[DFT_LEN-1];
            delta_im <= din_im - dly_im[DFT_LEN-1];
        end
    end

    // stage 2: add to previous state and rotate by the twiddle
    always_comb begin
        sum_re = dout_re + delta_re;
        sum_im = dout_im + delta_im;
        mul_re = sum_re * cfg.twiddle_re - sum_im * cfg.twiddle_im;
        mul_im = sum_re * cfg.twiddle_im + sum_im * cfg.twiddle_re;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dout_re <= '0;
            dout_im <= '0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= delta_valid;
            if (delta_valid) begin
                // truncate and wrap to the bin width
                dout_re <= corr_pkg::sdft_width'(mul_re >>> corr_pkg::twidd_point);
                dout_im <= corr_pkg::sdft_width'(mul_im >>> corr_pkg::twidd_point);
            end
        end
    end

endmodule

`default_nettype wire

//--- corr_regs.sv
`timescale 1ns/10ps
`default_nettype none

module corr_regs (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic [axil_pkg::addr_width-1:0] awaddr,
    input  wire logic awvalid,
    output logic awready,
    input  wire logic [31:0] wdata,
    input  wire logic [3:0] wstrb,
    input  wire logic wvalid,
    output logic wready,
    output axil_pkg::resp_e bresp,
    output logic bvalid,
    input  wire logic bready,
    input  wire logic [axil_pkg::addr_width-1:0] araddr,
    input  wire logic arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output axil_pkg::resp_e rresp,
    output logic rvalid,
    input  wire logic rready,
    corr_cfg_if.regs cfg
);

    axil_pkg::wr_state_e wr_state;
    logic [axil_pkg::addr_width-1:0] awaddr_q;
    logic [31:0] wdata_q;
    logic [3:0] wstrb_q;
    logic [axil_pkg::addr_width-1:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0] wr_strb;
    logic aw_hs;
    logic w_hs;
    logic do_write;

    logic enable_q;
    logic [31:0] twiddle_q;
    logic [31:0] acc_len_q;
    logic [31:0] frames_q;

    function automatic logic [31:0] apply_strb(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0] strb);
        logic [31:0] res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign aw_hs = awvalid && awready;
    assign w_hs = wvalid && wready;

    // a channel's ready is only high while its half is still missing
    assign do_write = (aw_hs || wr_state == axil_pkg::addr_only)
                   && (w_hs || wr_state == axil_pkg::data_only);

    always_comb begin
        wr_addr = aw_hs ? awaddr : awaddr_q;
        wr_data = w_hs ? wdata : wdata_q;
        wr_strb = w_hs ? wstrb : wstrb_q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= axil_pkg::idle;
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            enable_q <= 1'b0;
            // unity twiddle
            twiddle_q <= 32'h0000_4000;
            acc_len_q <= 32'd1;
        end else begin
            if (aw_hs) begin
                awaddr_q <= awaddr;
            end
            if (w_hs) begin
                wdata_q <= wdata;
                wstrb_q <= wstrb;
            end
            if (wr_state == axil_pkg::resp) begin
                if (bready) begin
                    bvalid <= 1'b0;
                    awready <= 1'b1;
                    wready <= 1'b1;
                    wr_state <= axil_pkg::idle;
                end
            end else if (do_write) begin
                awready <= 1'b0;
                wready <= 1'b0;
                bvalid <= 1'b1;
                bresp <= axil_pkg::okay;
                wr_state <= axil_pkg::resp;
                case (wr_addr)
                    axil_pkg::addr_ctrl: begin
                        if (wr_strb[0]) begin
                            enable_q <= wr_data[0];
                        end
                    end
                    axil_pkg::addr_twiddle: twiddle_q <= apply_strb(twiddle_q, wr_data, wr_strb);
                    axil_pkg::addr_acc_len: acc_len_q <= apply_strb(acc_len_q, wr_data, wr_strb);
                    // read-only, write is accepted and dropped
                    axil_pkg::addr_frames: ;
                    default: bresp <= axil_pkg::slverr;
                endcase
            end else if (aw_hs) begin
                awready <= 1'b0;
                wr_state <= axil_pkg::addr_only;
            end else if (w_hs) begin
                wready <= 1'b0;
                wr_state <= axil_pkg::data_only;
            end else if (wr_state == axil_pkg::idle) begin
                awready <= 1'b1;
                wready <= 1'b1;
            end
        end
    end

    // read channel, one address outstanding
    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
        end else if (rvalid) begin
            if (rready) begin
                rvalid <= 1'b0;
                arready <= 1'b1;
            end
        end else if (arvalid && arready) begin
            arready <= 1'b0;
            rvalid <= 1'b1;
            rresp <= axil_pkg::okay;
            case (araddr)
                axil_pkg::addr_ctrl: rdata <= {31'd0, enable_q};
                axil_pkg::addr_twiddle: rdata <= twiddle_q;
                axil_pkg::addr_acc_len: rdata <= acc_len_q;
                axil_pkg::addr_frames: rdata <= frames_q;
                default: begin
                    rdata <= 32'd0;
                    rresp <= axil_pkg::slverr;
                end
            endcase
        end else begin
            arready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frames_q <= 32'd0;
        end else if (cfg.frame_done) begin
            frames_q <= frames_q + 32'd1;
        end
    end

    assign cfg.enable = enable_q;
    assign cfg.twiddle_re = twiddle_q[15:0];
    assign cfg.twiddle_im = twiddle_q[31:16];
    // zero length behaves as one
    assign cfg.acc_len = (acc_len_q == 32'd0) ? 32'd1 : acc_len_q;

endmodule

`default_nettype wire

//--- corr_cfg_if.sv
`timescale 1ns/10ps
`default_nettype none

interface corr_cfg_if;

    logic enable;
    logic signed [corr_pkg::twidd_width-1:0] twiddle_re;
    logic signed [corr_pkg::twidd_width-1:0] twiddle_im;
    logic [31:0] acc_len;
    // one pulse per finished frame
    logic frame_done;

    modport regs (
        output enable, twiddle_re, twiddle_im, acc_len,
        input  frame_done
    );

    modport dp (
        input  enable, twiddle_re, twiddle_im, acc_len,
        output frame_done
    );

endinterface

`default_nettype wire

//--- axil_pkg.sv
`default_nettype none

package axil_pkg;

    localparam int addr_width = 8;

    // register byte addresses
    localparam logic [addr_width-1:0] addr_ctrl    = 8'h00;
    localparam logic [addr_width-1:0] addr_twiddle = 8'h04;
    localparam logic [addr_width-1:0] addr_acc_len = 8'h08;
    localparam logic [addr_width-1:0] addr_frames  = 8'h0c;

    typedef enum logic [1:0] {
        okay   = 2'b00,
        slverr = 2'b10
    } resp_e;

    // write channel, address and data may come in either order
    typedef enum logic [1:0] {
        idle,
        addr_only,
        data_only,
        resp
    } wr_state_e;

endpackage

`default_nettype wire

//--- corr_pkg.sv
`default_nettype none

package corr_pkg;

    // input samples, signed
    localparam int din_width = 8;

    // twiddle format, signed with 14 fraction bits
    localparam int twidd_width = 16;
    localparam int twidd_point = 14;

    // one bin value per channel
    localparam int sdft_width = 16;

    // full product width before the output shift
    localparam int prod_width = 2 * sdft_width + 1;
    localparam int prod_shift = 8;

    // accumulators wrap at this width
    localparam int acc_width = 32;

endpackage

`default_nettype wire
